//--- bench/sequencer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "seq_cfg.svh"

module sequencer_tb;
	import seq_io_pkg::*;

	logic    rst;
	logic    clk;
	cond_t   cond;
	action_t act;
	integer  seed;
	int      visit;

	sequencer_core UUT (
		.rst  (rst),
		.clk  (clk),
		.cond (cond),
		.act  (act)
	);

	// rst is the clock of this design
	always #5 rst = ~rst;

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1, "Stopping at the first error");
	endtask

	// Polls between the clock toggles and returns 1 ns after the rising edge
	task automatic next_edge();
		int   n;
		logic low_seen;
		n = 0;
		low_seen = 1'b0;
		#0.25;
		while (!(low_seen && rst) && n < 40)
		begin
			low_seen = low_seen | !rst;
			#0.5;
			n++;
		end
		if (n >= 40)
		begin
			$display("No rising clock edge seen within 20 ns");
			stop_run();
		end
		else
			#0.75;
	endtask

	function automatic cond_t cx(input int n);
		return cond_t'({{(`SEQ_COND_W - 1){1'b0}}, 1'b1} << (n - 1));
	endfunction

	// No y44, so y45 takes the top bit
	function automatic action_t ay(input int n);
		return action_t'({{(`SEQ_ACT_W - 1){1'b0}}, 1'b1} << (n == 45 ? 43 : n - 1));
	endfunction

	// Random don't-cares with the given bits forced
	function automatic cond_t rand_cond(input cond_t ones, input cond_t zeros);
		logic [31:0] r;
		r = $random(seed);
		return (cond_t'(r[`SEQ_COND_W-1:0]) | ones) & ~zeros;
	endfunction

	task automatic check_act(input action_t exp);
		assert (act == exp)
		else
		begin
			$display("** Error at time %0t: act = %h, expected %h", $time, act, exp);
			stop_run();
		end
	endtask

	task automatic step(input cond_t c, input action_t exp);
		cond = c;
		#3;
		check_act(exp);
		next_edge();
	endtask

	// Alternate start up to st_test
	task automatic reach_test();
		step(rand_cond(cx(1), cx(2)), ay(1));
		step(rand_cond('0, '0), ay(2) | ay(3) | ay(4) | ay(5));
		step(rand_cond('0, '0), ay(5) | ay(6) | ay(7) | ay(8) | ay(9));
	endtask

	// Idle through the fixed chain and back to idle
	task automatic start_chain();
		step(rand_cond(cx(1) | cx(2), '0), ay(3) | ay(4) | ay(5));
		step(rand_cond('0, '0), ay(2) | ay(3) | ay(5) | ay(13));
		step(rand_cond('0, '0), ay(3) | ay(14) | ay(15));
		step(rand_cond('0, '0), ay(3) | ay(5) | ay(16) | ay(17));
		step(rand_cond('0, '0), ay(9) | ay(18) | ay(19));
	endtask

	initial
	begin
		seed = 32'h34a3_4fce;
		rst = 1'b0;
		clk = 1'b0;
		cond = '0;
		repeat (4) next_edge();
		clk = 1'b1;

		step('0, '0);
		start_chain();
		step('0, '0);

		// Test state, wait state and back through st_load_b
		reach_test();
		step(rand_cond('0, cx(15)), ay(5) | ay(10) | ay(11));
		step(rand_cond(cx(16), '0), ay(12));
		step(rand_cond('0, '0), ay(2) | ay(3) | ay(4) | ay(5));
		step(rand_cond('0, '0), ay(5) | ay(6) | ay(7) | ay(8) | ay(9));

		// Screen leaf and release
		step(rand_cond(cx(15) | cx(21) | cx(20) | cx(4) | cx(6), '0), ay(18));
		step(rand_cond(cx(17) | cx(8), '0), ay(22));
		start_chain();

		// Branch body reached from the test state
		reach_test();
		step(rand_cond(cx(15) | cx(21) | cx(18) | cx(4) | cx(5) | cx(6), cx(20)),
			ay(3) | ay(5) | ay(6) | ay(7) | ay(13));
		step(rand_cond('0, '0), ay(3) | ay(14) | ay(15) | ay(37));
		step(rand_cond(cx(12), '0), ay(9));
		step(rand_cond('0, cx(17)), '0);

		// Dispatch, redispatch, then st_branch
		reach_test();
		step(rand_cond(cx(15), cx(21) | cx(18)), ay(3) | ay(4) | ay(5) | ay(10));
		step(rand_cond(cx(3), '0), ay(4) | ay(5) | ay(6) | ay(7));
		step(rand_cond('0, cx(19)), ay(4) | ay(5) | ay(16) | ay(20) | ay(21));
		step(rand_cond(cx(20) | cx(5) | cx(6), '0), ay(3) | ay(15) | ay(23));
		step(rand_cond('0, cx(17)), '0);

		// Same guard result on every visit
		for (visit = 0; visit < 6; visit++)
		begin
			reach_test();
			step(rand_cond('0, cx(15)), ay(5) | ay(10) | ay(11));
			step(rand_cond(cx(20) | cx(6), cx(16) | cx(21) | cx(3) | cx(4) | cx(5)),
				ay(3) | ay(5) | ay(13) | ay(30) | ay(45));
			step(rand_cond(cx(7), '0), ay(33) | ay(34));
			step(rand_cond('0, cx(17)), '0);
		end
		step('0, '0);

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/seq_io_pkg.sv
rtl/seq_state_pkg.sv
rtl/screen_decoder.sv
rtl/branch_decoder.sv
rtl/sequencer_core.sv
bench/sequencer_tb.sv

//--- rtl/branch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module branch_decoder (
	input  seq_io_pkg::cond_t        cond,
	output seq_state_pkg::decision_t dec
);
	import seq_io_pkg::*;
	import seq_state_pkg::*;

	logic load_en;

	// Enable for the y16/y17 load leaves
	always_comb
	begin
		if (cond.x4)
			load_en = cond.x6 ? cond.x11 : cond.x10;
		else if (cond.x5)
			load_en = cond.x6 ? cond.x13 : cond.x14;
		else
			load_en = cond.x6;
	end

	always_comb
	begin
		dec = release_decide(cond);
		if (cond.x20)
		begin
			if (cond.x5 && cond.x6)
				dec = '{st_release, action_t'{y3: 1'b1, y15: 1'b1, y23: 1'b1, default: 1'b0}};
			else if (cond.x5)
				dec = '{st_release, action_t'{y3: 1'b1, y5: 1'b1, y6: 1'b1, y7: 1'b1,
					y25: 1'b1, default: 1'b0}};
			else
				dec = '{st_guard_b, action_t'{y3: 1'b1, y6: 1'b1, y7: 1'b1, y30: 1'b1,
					y43: 1'b1, default: 1'b0}};
		end
		else if (!cond.x21)
		begin
			dec.nxt = st_release;
			dec.act = action_t'{y5: 1'b1, y6: 1'b1, y7: 1'b1, y24: 1'b1, y25: 1'b1,
				default: 1'b0};
			dec.act.y23 = !cond.x4;
		end
		else if (cond.x4 && cond.x5)
		begin
			if (cond.x6)
				dec = '{st_set_a, action_t'{y3: 1'b1, y5: 1'b1, y6: 1'b1, y7: 1'b1,
					y13: 1'b1, default: 1'b0}};
			else
				dec = '{st_set_b, action_t'{y2: 1'b1, y3: 1'b1, y15: 1'b1, y36: 1'b1,
					default: 1'b0}};
		end
		else if (load_en)
			dec = '{st_release, action_t'{y3: 1'b1, y5: 1'b1, y16: 1'b1, y17: 1'b1,
				default: 1'b0}};
		else if (!cond.x4 && !cond.x5)
			dec = '{st_release, action_t'{y35: 1'b1, default: 1'b0}};
		// Disabled load leaves keep the release rule
	end

endmodule

`default_nettype wire

//--- rtl/screen_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module screen_decoder (
	input  seq_io_pkg::cond_t        cond,
	output seq_state_pkg::decision_t dec
);
	import seq_io_pkg::*;
	import seq_state_pkg::*;

	// Caller has already seen x21 and x20 high
	always_comb
	begin
		dec = release_decide(cond);
		if (cond.x4)
		begin
			dec.nxt = st_release;
			if (cond.x6)
				dec.act = action_t'{y18: 1'b1, default: 1'b0};
			else
				dec.act = action_t'{y38: 1'b1, default: 1'b0};
		end
		else if (cond.x5)
		begin
			// x9 enables with x6 high, x8 without
			if (cond.x6 ? cond.x9 : cond.x8)
			begin
				dec.nxt = st_release;
				dec.act = action_t'{y9: 1'b1, default: 1'b0};
			end
		end
		else
		begin
			dec.nxt = st_release;
			if (cond.x6)
				dec.act = action_t'{y3: 1'b1, y5: 1'b1, y14: 1'b1, y39: 1'b1,
					y41: 1'b1, default: 1'b0};
			else
				dec.act = action_t'{y3: 1'b1, y5: 1'b1, y13: 1'b1, y40: 1'b1,
					y42: 1'b1, default: 1'b0};
		end
	end

endmodule

`default_nettype wire

//--- rtl/seq_cfg.svh
`ifndef SEQ_CFG_SVH
`define SEQ_CFG_SVH

// Condition inputs x1 to x21
`define SEQ_COND_W 21

// Action outputs y1 to y43 plus y45
`define SEQ_ACT_W 44

// Enough for the 22 machine states
`define SEQ_STATE_W 5

`endif

//--- rtl/seq_io_pkg.sv
`default_nettype none

package seq_io_pkg;

	// Condition word, x1 sits in bit 0
	typedef struct packed {
		logic x21;
		logic x20;
		logic x19;
		logic x18;
		logic x17;
		logic x16;
		logic x15;
		logic x14;
		logic x13;
		logic x12;
		logic x11;
		logic x10;
		logic x9;
		logic x8;
		logic x7;
		logic x6;
		logic x5;
		logic x4;
		logic x3;
		logic x2;
		logic x1;
	} cond_t;

	// Action word, y1 sits in bit 0 and there is no y44
	typedef struct packed {
		logic y45;
		logic y43;
		logic y42;
		logic y41;
		logic y40;
		logic y39;
		logic y38;
		logic y37;
		logic y36;
		logic y35;
		logic y34;
		logic y33;
		logic y32;
		logic y31;
		logic y30;
		logic y29;
		logic y28;
		logic y27;
		logic y26;
		logic y25;
		logic y24;
		logic y23;
		logic y22;
		logic y21;
		logic y20;
		logic y19;
		logic y18;
		logic y17;
		logic y16;
		logic y15;
		logic y14;
		logic y13;
		logic y12;
		logic y11;
		logic y10;
		logic y9;
		logic y8;
		logic y7;
		logic y6;
		logic y5;
		logic y4;
		logic y3;
		logic y2;
		logic y1;
	} action_t;

endpackage

`default_nettype wire

//--- rtl/seq_state_pkg.sv
`default_nettype none

`include "seq_cfg.svh"

package seq_state_pkg;
	import seq_io_pkg::*;

	// Codes follow benchmark states s1 to s22
	typedef enum logic [`SEQ_STATE_W-1:0] {
		st_idle,
		st_load_a,
		st_load_b,
		st_prep_a,
		st_prep_b,
		st_hold_a,
		st_test,
		st_close,
		st_release,
		st_set_a,
		st_set_b,
		st_dispatch,
		st_guard_a,
		st_wait,
		st_guard_b,
		st_redispatch,
		st_guard_c,
		st_branch,
		st_step_a,
		st_guard_d,
		st_guard_e,
		st_step_b
	} state_t;

	// One step of the machine
	typedef struct packed {
		state_t  nxt;
		action_t act;
	} decision_t;

	// Back to idle, y22 when x17 agrees with x8 or x9
	function automatic decision_t release_decide(input cond_t c);
		decision_t d;
		d.nxt = st_idle;
		d.act = '0;
		d.act.y22 = c.x17 & (c.x8 | c.x9);
		return d;
	endfunction

endpackage

`default_nettype wire

//--- rtl/sequencer_core.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer_core (
	input  logic                rst,
	input  logic                clk,
	input  seq_io_pkg::cond_t   cond,
	output seq_io_pkg::action_t act
);
	import seq_io_pkg::*;
	import seq_state_pkg::*;

	state_t    state;
	decision_t cur;
	decision_t screen_dec;
	decision_t branch_dec;

	// Guard step with its enable and word, release rule otherwise
	function automatic decision_t guard(input logic en, input action_t word, input cond_t c);
		decision_t d;
		d = release_decide(c);
		if (en)
		begin
			d.nxt = st_release;
			d.act = word;
		end
		return d;
	endfunction

	screen_decoder u_screen (
		.cond (cond),
		.dec  (screen_dec)
	);

	branch_decoder u_branch (
		.cond (cond),
		.dec  (branch_dec)
	);

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			state <= st_idle;
		else
			state <= cur.nxt;
	end

	assign act = cur.act;

	always_comb
	begin
		cur.nxt = st_idle;
		cur.act = '0;
		case (state)
			st_idle:
				if (cond.x1 && cond.x2)
					cur = '{st_load_a, action_t'{y3: 1'b1, y4: 1'b1, y5: 1'b1, default: 1'b0}};
				else if (cond.x1)
					cur = '{st_load_b, action_t'{y1: 1'b1, default: 1'b0}};
			st_load_a:
				cur = '{st_prep_a, action_t'{y2: 1'b1, y3: 1'b1, y5: 1'b1, y13: 1'b1,
					default: 1'b0}};
			st_load_b:
				cur = '{st_prep_b, action_t'{y2: 1'b1, y3: 1'b1, y4: 1'b1, y5: 1'b1,
					default: 1'b0}};
			st_prep_a:
				cur = '{st_hold_a, action_t'{y3: 1'b1, y14: 1'b1, y15: 1'b1, default: 1'b0}};
			st_prep_b:
				cur = '{st_test, action_t'{y5: 1'b1, y6: 1'b1, y7: 1'b1, y8: 1'b1, y9: 1'b1,
					default: 1'b0}};
			st_hold_a:
				cur = '{st_close, action_t'{y3: 1'b1, y5: 1'b1, y16: 1'b1, y17: 1'b1,
					default: 1'b0}};
			st_close:
				cur = '{st_idle, action_t'{y9: 1'b1, y18: 1'b1, y19: 1'b1, default: 1'b0}};
			st_test:
				if (!cond.x15)
					cur = '{st_wait, action_t'{y5: 1'b1, y10: 1'b1, y11: 1'b1, default: 1'b0}};
				else if (cond.x21 && cond.x20)
					cur = screen_dec;
				// With x20 low and x21 high this matches the branch body
				else if (cond.x21 && cond.x18)
					cur = branch_dec;
				else if (!cond.x18)
					cur = '{st_dispatch, action_t'{y3: 1'b1, y4: 1'b1, y5: 1'b1, y10: 1'b1,
						default: 1'b0}};
				else if (!cond.x20)
				begin
					cur = '{st_release, action_t'{y5: 1'b1, y10: 1'b1, y24: 1'b1, y25: 1'b1,
						default: 1'b0}};
					cur.act.y23 = !cond.x4;
				end
				else if (!cond.x5)
					cur = '{st_guard_a, action_t'{y3: 1'b1, y10: 1'b1, y30: 1'b1, y43: 1'b1,
						default: 1'b0}};
				else
				begin
					cur = '{st_release, action_t'{y3: 1'b1, y5: 1'b1, y10: 1'b1, default: 1'b0}};
					cur.act.y29 = cond.x6;
					cur.act.y25 = !cond.x6;
				end
			st_release:
				cur = release_decide(cond);
			st_set_a:
				cur = '{st_guard_c, action_t'{y3: 1'b1, y14: 1'b1, y15: 1'b1, y37: 1'b1,
					default: 1'b0}};
			st_set_b:
				cur = '{st_release, action_t'{y3: 1'b1, y5: 1'b1, y16: 1'b1, y17: 1'b1,
					default: 1'b0}};
			st_dispatch, st_redispatch:
				if (state == st_dispatch && cond.x3)
					cur = '{st_redispatch, action_t'{y4: 1'b1, y5: 1'b1, y6: 1'b1, y7: 1'b1,
						default: 1'b0}};
				else if (cond.x19)
					cur = branch_dec;
				else
					cur = '{st_branch, action_t'{y4: 1'b1, y5: 1'b1, y16: 1'b1, y20: 1'b1,
						y21: 1'b1, default: 1'b0}};
			st_branch:
				cur = branch_dec;
			st_wait:
				if (cond.x16)
					cur = '{st_load_b, action_t'{y12: 1'b1, default: 1'b0}};
				else if (cond.x21 && cond.x20)
					cur = screen_dec;
				else if (cond.x21 || cond.x3)
					cur = '{st_branch, action_t'{y3: 1'b1, y4: 1'b1, y5: 1'b1, y20: 1'b1,
						default: 1'b0}};
				else if (!cond.x20)
				begin
					cur = '{st_release, action_t'{y24: 1'b1, y25: 1'b1, default: 1'b0}};
					cur.act.y5 = cond.x5 || !cond.x4;
					cur.act.y6 = cond.x4 && !cond.x5;
					cur.act.y20 = !(cond.x4 && cond.x5);
					cur.act.y23 = cond.x5 || !cond.x4;
				end
				else if (cond.x4)
				begin
					cur.nxt = st_release;
					if (cond.x5)
						cur.act = cond.x6 ? action_t'{y28: 1'b1, default: 1'b0}
							: action_t'{y26: 1'b1, default: 1'b0};
					else if (cond.x6)
						cur.act = action_t'{y27: 1'b1, default: 1'b0};
					else
						cur = '{st_step_a, action_t'{y3: 1'b1, y5: 1'b1, y13: 1'b1,
							y23: 1'b1, default: 1'b0}};
				end
				else if (cond.x5)
				begin
					cur = '{st_release, action_t'{y3: 1'b1, y5: 1'b1, default: 1'b0}};
					cur.act.y23 = cond.x6;
					cur.act.y29 = cond.x6;
					cur.act.y20 = !cond.x6;
					cur.act.y25 = !cond.x6;
				end
				else if (cond.x6)
					cur = '{st_guard_d, action_t'{y3: 1'b1, y5: 1'b1, y13: 1'b1, y30: 1'b1,
						y45: 1'b1, default: 1'b0}};
				else
					cur = '{st_guard_e, action_t'{y3: 1'b1, y20: 1'b1, y30: 1'b1, y43: 1'b1,
						default: 1'b0}};
			st_guard_a, st_guard_b, st_guard_e:
				cur = guard(cond.x7, action_t'{y31: 1'b1, y32: 1'b1, default: 1'b0}, cond);
			st_guard_c:
				cur = guard(cond.x12, action_t'{y9: 1'b1, default: 1'b0}, cond);
			st_guard_d:
				cur = guard(cond.x7, action_t'{y33: 1'b1, y34: 1'b1, default: 1'b0}, cond);
			st_step_a:
				cur = '{st_step_b, action_t'{y3: 1'b1, y5: 1'b1, y20: 1'b1, y25: 1'b1,
					default: 1'b0}};
			st_step_b:
				cur = '{st_release, action_t'{y3: 1'b1, y5: 1'b1, y14: 1'b1, y29: 1'b1,
					default: 1'b0}};
			// Unused codes return to idle
			default:
				cur.nxt = st_idle;
		endcase
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module sequencer_tb -o sequencer_sim
./obj_dir/sequencer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log
then
	exit 1
fi
